//--- filelist.f
+incdir+.
cache_pkg.sv
fetch_pkg.sv
icache_array.sv
icache_ctrl.sv
pc_gen.sv
ifetch_top.sv
ifetch_checker.sv
tb_ifetch.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ifetch
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Done: errors found

SOURCES := $(shell grep -v '^+' $(FILELIST)) ifetch_settings.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_ifetch.sv
`include "ifetch_settings.svh"

module tb_ifetch
    import cache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    TIMEOUT   = 2000;
    localparam addr_t LOOP_LAST = addr_t'((`IFETCH_LINES - 2) * 4); // spare line for stale fetch.

    logic  clk;
    logic  rst;
    logic  stall;
    logic  redirect;
    addr_t redirect_pc;
    logic  invalidate;
    logic  inst_valid;
    word_t inst;
    addr_t inst_pc;
    logic  mem_req_valid;
    addr_t mem_req_addr;
    logic  mem_ready;
    word_t mem_data;
    int    seed            = 10135;
    int    delivered       = 0;
    int    region_requests = 0;
    int    value_errors    = 0;
    int    timeout_errors  = 0;
    addr_t last_pc         = '0;

    ifetch_top DUT (.*);

    bind ifetch_top ifetch_checker checks (.*);

    function automatic word_t memory_word(input addr_t addr);
        return {addr, ~addr};
    endfunction

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (!rst && inst_valid)
        begin
            delivered++;
            last_pc = inst_pc;
        end
    end

    initial
    begin : memory_model
        int latency;
        mem_ready = 1'b0;
        mem_data  = '0;
        forever
        begin
            @(posedge clk);
            #1;
            if (!rst && mem_req_valid)
            begin
                latency = 1 + int'(($random(seed) & 32'h7fff_ffff) % 6); // 1 to 6 cycles.
                repeat (latency - 1)
                begin
                    @(posedge clk);
                    #1;
                end
                mem_ready = 1'b1;
                mem_data  = memory_word(mem_req_addr);
                if (mem_req_addr <= LOOP_LAST)
                    region_requests++;
                @(posedge clk);
                #1;
                mem_ready = 1'b0;
            end
        end
    end

    task automatic check_value(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic steer(input addr_t target);
        redirect    = 1'b1;
        redirect_pc = target;
        @(posedge clk);
        #1;
        redirect = 1'b0;
    endtask

    // waits for a refill of target, or for target to reach decode.
    task automatic wait_for(input string name, input bit on_miss, input addr_t target,
                            input bit stalls);
        int cycles;
        int seen;
        bit done;
        cycles = 0;
        done   = 1'b0;
        while (!done && timeout_errors == 0)
        begin
            seen  = delivered;
            stall = stalls && (($random(seed) & 3) == 0);
            @(posedge clk);
            #1;
            cycles++;
            if (on_miss)
                done = mem_req_valid && (mem_req_addr == target);
            else
                done = (delivered != seen) && (last_pc == target);
            if (!done && cycles >= TIMEOUT)
            begin
                $display("TIMEOUT: %s saw no sign of pc %h in %0d cycles", name, target, cycles);
                timeout_errors++;
            end
        end
        stall = 1'b0;
    endtask

    // requests below zero skip the memory count.
    task automatic run_segment(input string name, input addr_t start_pc, input addr_t end_pc,
                               input bit stalls, input int requests);
        int count_mark;
        int request_mark;
        count_mark   = delivered;
        request_mark = region_requests;
        steer(start_pc);
        wait_for(name, 1'b0, end_pc, stalls);
        if (timeout_errors == 0)
        begin
            check_value({name, " count"}, int'((end_pc - start_pc) >> 2) + 1,
                        delivered - count_mark);
            if (requests >= 0)
                check_value({name, " requests"}, requests, region_requests - request_mark);
        end
    endtask

    initial
    begin
        rst         = 1'b1;
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        invalidate  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        wait_for("straight_run", 1'b0, 16'h00bc, 1'b0);
        check_value("straight_run count", 48, delivered);
        run_segment("loop_pass_1", '0, LOOP_LAST, 1'b1, 15);
        run_segment("loop_pass_2", '0, LOOP_LAST, 1'b1, 0); // all hits.
        steer(16'h0402); // refill asks for the aligned word.
        wait_for("miss_redirect", 1'b1, 16'h0400, 1'b0);
        run_segment("miss_redirect", 16'h0844, 16'h0860, 1'b0, -1);
        invalidate = 1'b1;
        @(posedge clk);
        #1;
        invalidate = 1'b0;
        run_segment("loop_pass_3", '0, LOOP_LAST, 1'b1, 15);
        $display("errors: value %0d, timeout %0d, assertion %0d",
                 value_errors, timeout_errors, DUT.checks.failures);
        if (value_errors + timeout_errors + DUT.checks.failures == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- ifetch_checker.sv
module ifetch_checker import cache_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  stall,
    input logic  redirect,
    input addr_t redirect_pc,
    input logic  inst_valid,
    input word_t inst,
    input addr_t inst_pc,
    input logic  mem_req_valid,
    input addr_t mem_req_addr,
    input logic  mem_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    int    failures = 0;
    addr_t next_pc; // pc decode should see next.

    function automatic word_t stored_word(input addr_t addr);
        return {addr, ~addr};
    endfunction

    task automatic count_failure(input string what);
        failures++;
        $error("%s", what);
    endtask

    always_ff @(posedge clk)
    begin
        if (rst)
            next_pc <= '0;
        else if (redirect)
            next_pc <= redirect_pc;
        else if (inst_valid)
            next_pc <= inst_pc + addr_t'(4);
    end

    inst_matches_memory: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> inst == stored_word(inst_pc))
        else count_failure($sformatf("CHECK FAILED inst_value: expected %h, actual %h",
                                     stored_word(inst_pc), inst));
    pc_in_order: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> inst_pc == next_pc)
        else count_failure($sformatf("CHECK FAILED inst_pc: expected %h, actual %h",
                                     next_pc, inst_pc));
    mem_req_held: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_ready |=> mem_req_valid && $stable(mem_req_addr))
        else count_failure("memory request changed before mem_ready");
    mem_req_drops: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && mem_ready |=> !mem_req_valid)
        else count_failure("memory request still high after mem_ready");
    mem_addr_aligned: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid |-> mem_req_addr[1:0] == 2'b00)
        else count_failure("memory request address is not word aligned");
    no_inst_in_stall: assert property (@(posedge clk) disable iff (rst)
        stall |-> !inst_valid)
        else count_failure("instruction delivered while decode stalls");
    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !inst_valid && !mem_req_valid)
        else count_failure("fetch outputs active right after reset");

endmodule

//--- ifetch_top.sv
module ifetch_top import cache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  stall,
    input  logic  redirect,
    input  addr_t redirect_pc,
    input  logic  invalidate,
    output logic  inst_valid,
    output word_t inst,
    output addr_t inst_pc,
    output logic  mem_req_valid,
    output addr_t mem_req_addr,
    input  logic  mem_ready,
    input  word_t mem_data
);

    logic   fetch_req;
    addr_t  fetch_addr;
    logic   accept;
    logic   resp_valid;
    word_t  resp_data;
    index_t lookup_index;
    tag_t   lookup_tag;
    logic   hit;
    word_t  hit_data;
    logic   fill_en;
    index_t fill_index;
    tag_t   fill_tag;
    word_t  fill_data;

    pc_gen u_pc_gen
    (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .accept      (accept),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc)
    );

    icache_ctrl u_icache_ctrl
    (
        .clk           (clk),
        .rst           (rst),
        .fetch_req     (fetch_req),
        .fetch_addr    (fetch_addr),
        .accept        (accept),
        .resp_valid    (resp_valid),
        .resp_data     (resp_data),
        .lookup_index  (lookup_index),
        .lookup_tag    (lookup_tag),
        .hit           (hit),
        .hit_data      (hit_data),
        .fill_en       (fill_en),
        .fill_index    (fill_index),
        .fill_tag      (fill_tag),
        .fill_data     (fill_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_ready     (mem_ready),
        .mem_data      (mem_data)
    );

    icache_array u_icache_array
    (
        .clk          (clk),
        .rst          (rst),
        .invalidate   (invalidate),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .hit          (hit),
        .hit_data     (hit_data),
        .fill_en      (fill_en),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .fill_data    (fill_data)
    );

endmodule

//--- pc_gen.sv
module pc_gen import cache_pkg::*, fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  stall,
    input  logic  redirect,
    input  addr_t redirect_pc,
    output logic  fetch_req,
    output addr_t fetch_addr,
    input  logic  accept,
    input  logic  resp_valid,
    input  word_t resp_data,
    output logic  inst_valid,
    output word_t inst,
    output addr_t inst_pc
);

    fetch_state_t state;
    addr_t        pc;
    logic         out_full;
    word_t        inst_q;
    addr_t        inst_pc_q;

    assign fetch_req  = (state == fetch_issue) && !stall && !redirect;
    assign fetch_addr = pc;

    // a redirect squashes the word behind the branch.
    assign inst_valid = out_full && !stall && !redirect;
    assign inst       = inst_q;
    assign inst_pc    = inst_pc_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= fetch_issue;
            pc       <= '0;
            out_full <= 1'b0;
        end
        else
        begin
            if (inst_valid || redirect)
                out_full <= 1'b0;
            case (state)
                fetch_issue:
                    if (accept)
                        state <= fetch_wait;
                fetch_wait:
                begin
                    if (redirect)
                    begin
                        state <= resp_valid ? fetch_issue : fetch_discard;
                    end
                    else if (resp_valid)
                    begin
                        out_full <= 1'b1;
                        pc       <= pc + addr_t'(4);
                        state    <= fetch_issue;
                    end
                end
                fetch_discard:
                    if (resp_valid)
                        state <= fetch_issue; // stale word dropped.
                default:
                    state <= fetch_issue;
            endcase
            if (redirect)
                pc <= redirect_pc;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == fetch_wait && resp_valid)
        begin
            inst_q    <= resp_data;
            inst_pc_q <= pc;
        end
    end

endmodule

//--- icache_ctrl.sv
`include "ifetch_settings.svh"

module icache_ctrl import cache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   fetch_req,
    input  addr_t  fetch_addr,
    output logic   accept,
    output logic   resp_valid,
    output word_t  resp_data,
    output index_t lookup_index,
    output tag_t   lookup_tag,
    input  logic   hit,
    input  word_t  hit_data,
    output logic   fill_en,
    output index_t fill_index,
    output tag_t   fill_tag,
    output word_t  fill_data,
    output logic   mem_req_valid,
    output addr_t  mem_req_addr,
    input  logic   mem_ready,
    input  word_t  mem_data
);

    cache_state_t state;
    cache_state_t state_next;
    addr_t        addr_q;

    assign accept = (state == cache_idle) && fetch_req;

    assign lookup_index = addr_q[`IFETCH_INDEX_MSB:`IFETCH_INDEX_LSB];
    assign lookup_tag   = addr_q[`IFETCH_ADDR_W-1:`IFETCH_TAG_LSB];

    assign resp_valid = (state == cache_lookup) && hit;
    assign resp_data  = hit_data;

    // request held through the whole refill state.
    assign mem_req_valid = (state == cache_refill);
    assign mem_req_addr  = {addr_q[`IFETCH_ADDR_W-1:`IFETCH_INDEX_LSB],
                            {`IFETCH_INDEX_LSB{1'b0}}};

    assign fill_en    = (state == cache_refill) && mem_ready;
    assign fill_index = lookup_index;
    assign fill_tag   = lookup_tag;
    assign fill_data  = mem_data;

    always_comb
    begin
        state_next = state;
        case (state)
            cache_idle:
                if (fetch_req)
                    state_next = cache_lookup;
            cache_lookup:
                state_next = hit ? cache_idle : cache_refill;
            cache_refill:
                if (mem_ready)
                    state_next = cache_lookup; // second lookup now hits.
            default:
                state_next = cache_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= cache_idle;
        else
            state <= state_next;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            addr_q <= fetch_addr;
    end

endmodule

//--- icache_array.sv
`include "ifetch_settings.svh"

module icache_array import cache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   invalidate,
    input  index_t lookup_index,
    input  tag_t   lookup_tag,
    output logic   hit,
    output word_t  hit_data,
    input  logic   fill_en,
    input  index_t fill_index,
    input  tag_t   fill_tag,
    input  word_t  fill_data
);

    logic [`IFETCH_LINES-1:0] valid;
    tag_t                     tag_mem  [`IFETCH_LINES];
    word_t                    data_mem [`IFETCH_LINES];

    assign hit      = valid[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
    assign hit_data = data_mem[lookup_index];

    always_ff @(posedge clk)
    begin
        if (rst || invalidate)
        begin
            valid <= '0; // wins over a fill in the same cycle.
        end
        else if (fill_en)
        begin
            valid[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            tag_mem[fill_index]  <= fill_tag;
            data_mem[fill_index] <= fill_data;
        end
    end

endmodule

//--- fetch_pkg.sv
package fetch_pkg;

    // wait holds a live request, discard one made stale by a redirect.
    typedef enum logic [1:0]
    {
        fetch_issue,
        fetch_wait,
        fetch_discard
    } fetch_state_t;

endpackage

//--- cache_pkg.sv
`include "ifetch_settings.svh"

package cache_pkg;

    typedef logic [`IFETCH_ADDR_W-1:0] addr_t; // byte address.
    typedef logic [`IFETCH_WORD_W-1:0] word_t; // one instruction.
    typedef logic [`IFETCH_INDEX_MSB-`IFETCH_INDEX_LSB:0] index_t;
    typedef logic [`IFETCH_ADDR_W-`IFETCH_TAG_LSB-1:0] tag_t;

    typedef enum logic [1:0]
    {
        cache_idle,
        cache_lookup,
        cache_refill
    } cache_state_t;

endpackage

//--- ifetch_settings.svh
`ifndef IFETCH_SETTINGS_SVH
`define IFETCH_SETTINGS_SVH

// byte address and instruction word.
`define IFETCH_ADDR_W 16
`define IFETCH_WORD_W 32

// direct mapped, one word per line.
`define IFETCH_LINES 16

// address split: tag | index | byte offset.
`define IFETCH_INDEX_LSB 2
`define IFETCH_INDEX_MSB 5
`define IFETCH_TAG_LSB 6

`endif
